// File: src/spmm_params_pkg.sv
package spmm_params_pkg;

    // matrix size, also the nonzero count of one job
    localparam int N = 16;

    // element width, all arithmetic wraps at this width
    localparam int W = 8;

    // column index width
    localparam int IDX_W = $clog2(N);

    // one extra bit so a row end can reach N
    localparam int END_W = IDX_W + 1;

    // rows moved per transfer cycle, on both load and drain
    localparam int BLOCK_ROWS = 4;

    // transfer cycles per matrix
    localparam int NUM_BLOCKS = N / BLOCK_ROWS;

    // segmented scan depth
    localparam int NUM_LEVELS = $clog2(N);

    // accepting edge to first output block
    // decode, multiply, scan levels, gather, drain
    localparam int PIPE_LATENCY = NUM_LEVELS + 4;

endpackage

// File: src/spmm_types_pkg.sv
package spmm_types_pkg;

    import spmm_params_pkg::*;

    // one matrix element
    typedef logic [W-1:0] data_t;

    // column of a nonzero
    typedef logic [IDX_W-1:0] col_idx_t;

    // cumulative row end, 0 to N
    typedef logic [END_W-1:0] row_end_t;

    // one full matrix row, element c is column c
    typedef data_t [N-1:0] dense_row_t;

    // load transfer, four rows per cycle
    typedef dense_row_t [BLOCK_ROWS-1:0] rhs_block_t;

    // held right-hand matrix, indexed by row
    typedef dense_row_t [N-1:0] rhs_matrix_t;

    // compressed-row sparse job
    // nonzero k has values[k] and cols[k]
    // row r ends before row_ends[r]
    typedef struct packed {
        data_t    [N-1:0] values;
        col_idx_t [N-1:0] cols;
        row_end_t [N-1:0] row_ends;
    } lhs_job_t;

    // what moves through the scan levels
    // one lane per nonzero, each lane spans all output columns
    typedef struct packed {
        dense_row_t [N-1:0] lanes;
        logic       [N-1:0] heads;
        row_end_t   [N-1:0] row_ends;
    } scan_frame_t;

    // full product, row r at index r
    typedef dense_row_t [N-1:0] result_t;

    // drain transfer, four rows per cycle
    typedef dense_row_t [BLOCK_ROWS-1:0] out_block_t;

endpackage

// File: src/rhs_loader.sv
module rhs_loader
    import spmm_params_pkg::*, spmm_types_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        rhs_start,
    input  rhs_block_t  rhs_rows,
    output logic        rhs_ready,
    output logic        rhs_loaded,
    output rhs_matrix_t rhs_matrix
);

    typedef enum logic {
        S_IDLE,
        S_LOAD
    } load_state_t;

    load_state_t                   state;
    logic [$clog2(NUM_BLOCKS)-1:0] block;
    logic [$clog2(NUM_BLOCKS)-1:0] wr_block;
    logic                          write_en;
    logic                          last_block;

    // strobe cycle already carries block 0
    assign write_en   = (state == S_IDLE) ? rhs_start : 1'b1;
    assign wr_block   = (state == S_IDLE) ? '0 : block;
    assign last_block = (wr_block == NUM_BLOCKS - 1);

    // only idle takes a new strobe
    assign rhs_ready = (state == S_IDLE);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state      <= S_IDLE;
            block      <= '0;
            rhs_loaded <= 1'b0;
        end else if (write_en) begin
            if (last_block) begin
                // matrix complete on this edge
                state      <= S_IDLE;
                block      <= '0;
                rhs_loaded <= 1'b1;
            end else begin
                // old contents are partly overwritten, not usable
                state      <= S_LOAD;
                block      <= wr_block + 1'b1;
                rhs_loaded <= 1'b0;
            end
        end
    end

    // four rows land per cycle
    always_ff @(posedge clock) begin
        if (write_en) begin
            for (int i = 0; i < BLOCK_ROWS; i++) begin
                rhs_matrix[wr_block * BLOCK_ROWS + i] <= rhs_rows[i];
            end
        end
    end

endmodule

// File: src/job_decode.sv
module job_decode
    import spmm_params_pkg::*, spmm_types_pkg::*;
(
    input  logic           clock,
    input  logic           reset,
    input  logic           lhs_start,
    input  lhs_job_t       lhs_job,
    input  logic           rhs_loaded,
    output logic           lhs_ready,
    output logic           job_valid,
    output lhs_job_t       job,
    output logic [N-1:0]   heads
);

    logic [$clog2(NUM_BLOCKS)-1:0] pace;
    logic                          accept;
    logic [N-1:0]                  head_next;

    // one job per drain window, so the drain is always free in time
    assign lhs_ready = rhs_loaded && (pace == '0);
    assign accept    = lhs_start && lhs_ready;

    // a lane opens a segment at 0 or wherever some row ends
    // empty rows just repeat a row end and mark nothing new
    always_comb begin
        head_next    = '0;
        head_next[0] = 1'b1;
        for (int k = 1; k < N; k++) begin
            for (int r = 0; r < N; r++) begin
                if (lhs_job.row_ends[r] == END_W'(k)) begin
                    head_next[k] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pace      <= '0;
            job_valid <= 1'b0;
        end else begin
            job_valid <= accept;
            if (accept) begin
                // hold off for the rest of the window
                pace <= $clog2(NUM_BLOCKS)'(NUM_BLOCKS - 1);
            end else if (pace != '0) begin
                pace <= pace - 1'b1;
            end
        end
    end

    // job and its segment flags move together
    always_ff @(posedge clock) begin
        if (accept) begin
            job   <= lhs_job;
            heads <= head_next;
        end
    end

endmodule

// File: src/product_array.sv
module product_array
    import spmm_params_pkg::*, spmm_types_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  logic         job_valid,
    input  lhs_job_t     job,
    input  logic [N-1:0] heads,
    input  rhs_matrix_t  rhs_matrix,
    output logic         frame_valid,
    output scan_frame_t  frame
);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= job_valid;
        end
    end

    // N x N multipliers, one per lane and output column
    // lane k reads dense row cols[k]
    // products keep only the low W bits
    always_ff @(posedge clock) begin
        if (job_valid) begin
            for (int k = 0; k < N; k++) begin
                for (int c = 0; c < N; c++) begin
                    frame.lanes[k][c] <= job.values[k] * rhs_matrix[job.cols[k]][c];
                end
            end
            // segment info rides along unchanged
            frame.heads    <= heads;
            frame.row_ends <= job.row_ends;
        end
    end

endmodule

// File: src/scan_level.sv
module scan_level
    import spmm_params_pkg::*, spmm_types_pkg::*;
#(
    parameter int DIST = 1
)
(
    input  logic        clock,
    input  logic        reset,
    input  logic        in_valid,
    input  scan_frame_t in_frame,
    output logic        out_valid,
    output scan_frame_t out_frame
);

    scan_frame_t next_frame;

    // one Hillis-Steele step of a segmented sum
    // lane k combines with lane k-DIST unless a head stops it
    always_comb begin
        next_frame = in_frame;
        for (int k = DIST; k < N; k++) begin
            if (!in_frame.heads[k]) begin
                for (int c = 0; c < N; c++) begin
                    next_frame.lanes[k][c] = in_frame.lanes[k][c] + in_frame.lanes[k-DIST][c];
                end
            end
            // a head anywhere in the window closes it for later levels
            next_frame.heads[k] = in_frame.heads[k] | in_frame.heads[k-DIST];
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (in_valid) begin
            out_frame <= next_frame;
        end
    end

endmodule

// File: src/row_gather.sv
module row_gather
    import spmm_params_pkg::*, spmm_types_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        in_valid,
    input  scan_frame_t in_frame,
    output logic        result_valid,
    output result_t     result
);

    result_t result_next;

    // last lane of each row now holds the whole row sum
    // lanes past the final row end are never picked
    always_comb begin
        row_end_t row_start;
        row_end_t row_stop;
        row_start = '0;
        for (int r = 0; r < N; r++) begin
            row_stop = in_frame.row_ends[r];
            if (row_stop > row_start) begin
                result_next[r] = in_frame.lanes[IDX_W'(row_stop - 1'b1)];
            end else begin
                // empty row
                result_next[r] = '0;
            end
            row_start = row_stop;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= in_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (in_valid) begin
            result <= result_next;
        end
    end

endmodule

// File: src/result_drain.sv
module result_drain
    import spmm_params_pkg::*, spmm_types_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       result_valid,
    input  result_t    result,
    output logic       out_valid,
    output out_block_t out_rows
);

    result_t                       held;
    logic [$clog2(NUM_BLOCKS)-1:0] block;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            out_valid <= 1'b0;
            block     <= '0;
        end else if (result_valid) begin
            // pacing lets a new result land on the last block edge
            out_valid <= 1'b1;
            block     <= '0;
        end else if (out_valid) begin
            if (block == NUM_BLOCKS - 1) begin
                out_valid <= 1'b0;
                block     <= '0;
            end else begin
                block <= block + 1'b1;
            end
        end
    end

    // whole matrix captured at once, drained from the copy
    always_ff @(posedge clock) begin
        if (result_valid) begin
            held <= result;
        end
    end

    // rows 4b to 4b+3 in block b
    always_comb begin
        for (int i = 0; i < BLOCK_ROWS; i++) begin
            out_rows[i] = held[block * BLOCK_ROWS + i];
        end
    end

endmodule

// File: src/spmm_top.sv
module spmm_top
    import spmm_params_pkg::*, spmm_types_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       rhs_start,
    input  rhs_block_t rhs_rows,
    output logic       rhs_ready,
    input  logic       lhs_start,
    input  lhs_job_t   lhs_job,
    output logic       lhs_ready,
    output logic       out_valid,
    output out_block_t out_rows
);

    rhs_matrix_t         rhs_matrix;
    logic                rhs_loaded;
    logic                job_valid;
    lhs_job_t            job;
    logic [N-1:0]        heads;
    // index 0 is the product stage, index NUM_LEVELS the finished scan
    logic [NUM_LEVELS:0] scan_valid;
    scan_frame_t         scan_frame [NUM_LEVELS+1];
    logic                result_valid;
    result_t             result;

    rhs_loader rhs_loader_i (
        .clock      (clock),
        .reset      (reset),
        .rhs_start  (rhs_start),
        .rhs_rows   (rhs_rows),
        .rhs_ready  (rhs_ready),
        .rhs_loaded (rhs_loaded),
        .rhs_matrix (rhs_matrix)
    );

    job_decode job_decode_i (
        .clock      (clock),
        .reset      (reset),
        .lhs_start  (lhs_start),
        .lhs_job    (lhs_job),
        .rhs_loaded (rhs_loaded),
        .lhs_ready  (lhs_ready),
        .job_valid  (job_valid),
        .job        (job),
        .heads      (heads)
    );

    product_array product_array_i (
        .clock       (clock),
        .reset       (reset),
        .job_valid   (job_valid),
        .job         (job),
        .heads       (heads),
        .rhs_matrix  (rhs_matrix),
        .frame_valid (scan_valid[0]),
        .frame       (scan_frame[0])
    );

    // distances 1, 2, 4, 8
    for (genvar l = 0; l < NUM_LEVELS; l++) begin : g_scan
        scan_level #(
            .DIST (1 << l)
        ) scan_level_i (
            .clock     (clock),
            .reset     (reset),
            .in_valid  (scan_valid[l]),
            .in_frame  (scan_frame[l]),
            .out_valid (scan_valid[l+1]),
            .out_frame (scan_frame[l+1])
        );
    end

    row_gather row_gather_i (
        .clock        (clock),
        .reset        (reset),
        .in_valid     (scan_valid[NUM_LEVELS]),
        .in_frame     (scan_frame[NUM_LEVELS]),
        .result_valid (result_valid),
        .result       (result)
    );

    result_drain result_drain_i (
        .clock        (clock),
        .reset        (reset),
        .result_valid (result_valid),
        .result       (result),
        .out_valid    (out_valid),
        .out_rows     (out_rows)
    );

endmodule

// File: verif/spmm_tests.svh
`ifndef SPMM_TESTS_SVH
`define SPMM_TESTS_SVH

function automatic rhs_matrix_t random_matrix();
    rhs_matrix_t m;
    for (int r = 0; r < N; r++) begin
        for (int c = 0; c < N; c++) begin
            m[r][c] = data_t'($random(seed));
        end
    end
    return m;
endfunction

function automatic lhs_job_t random_job();
    lhs_job_t job;
    int       last;
    int       stop;
    // last row end stays below N, so the top nonzeros are dropped
    stop = N - 2 - ($random(seed) & 3);
    last = 0;
    for (int k = 0; k < N; k++) begin
        job.values[k] = data_t'($random(seed));
        job.cols[k]   = col_idx_t'($random(seed));
    end
    for (int r = 0; r < N; r++) begin
        // row 0 spans nine or ten lanes so even the widest scan level adds
        // rows 1 and 5 always empty, others take 0 to 3 nonzeros
        if (r == 0) begin
            last = 9 + ($random(seed) & 1);
        end else if (r != 1 && r != 5) begin
            last = last + ($random(seed) & 3);
        end
        if (last > stop) begin
            last = stop;
        end
        job.row_ends[r] = row_end_t'(last);
    end
    return job;
endfunction

// called and returns 1 ns after a rising edge
task automatic load_rhs(input rhs_matrix_t m);
    int wait_cycles;
    wait_cycles = 0;
    while (!rhs_ready && wait_cycles < READY_WAIT) begin
        @(posedge clock);
        #1;
        wait_cycles++;
    end
    if (!rhs_ready) begin
        errors++;
        $display("load_rhs: rhs_ready stayed low, matrix not loaded");
        return;
    end
    rhs_start = 1'b1;
    for (int b = 0; b < NUM_BLOCKS; b++) begin
        for (int i = 0; i < BLOCK_ROWS; i++) begin
            rhs_rows[i] = m[b * BLOCK_ROWS + i];
        end
        @(posedge clock);
        #1;
        rhs_start = 1'b0;
        // busy until the last block lands
        if (b < NUM_BLOCKS - 1) begin
            check_flag("load busy rhs_ready", 1'b0, rhs_ready);
            check_flag("load busy lhs_ready", 1'b0, lhs_ready);
        end
    end
    rhs_rows   = '0;
    loaded_rhs = m;
    check_flag("load done rhs_ready", 1'b1, rhs_ready);
endtask

// strobe as soon as lhs_ready is seen, report the accepting edge
task automatic issue_job(input lhs_job_t job, output int unsigned accept_edge);
    int wait_cycles;
    wait_cycles = 0;
    while (!lhs_ready && wait_cycles < READY_WAIT) begin
        @(posedge clock);
        #1;
        wait_cycles++;
    end
    if (!lhs_ready) begin
        errors++;
        $display("issue_job: lhs_ready stayed low, job will not be accepted");
    end
    lhs_start = 1'b1;
    lhs_job   = job;
    @(posedge clock);
    #1;
    accept_edge = edge_count;
    lhs_start   = 1'b0;
endtask

// first block is taken at edge accept + PIPE_LATENCY, so check the negedge before
// idle_around also checks the drain is quiet on both sides of the job
task automatic drain_expect(input string name, input int unsigned accept_edge,
                            input result_t expected, input bit idle_around);
    int unsigned first_edge;
    out_block_t  exp_block;
    string       block_name;
    first_edge = accept_edge + PIPE_LATENCY - 1;
    while (edge_count < first_edge) begin
        @(negedge clock);
        if (idle_around && edge_count == first_edge - 1) begin
            check_flag({name, " before drain"}, 1'b0, out_valid);
        end
    end
    for (int b = 0; b < NUM_BLOCKS; b++) begin
        if (b > 0) begin
            @(negedge clock);
        end
        for (int i = 0; i < BLOCK_ROWS; i++) begin
            exp_block[i] = expected[b * BLOCK_ROWS + i];
        end
        block_name = $sformatf("%s block %0d", name, b);
        check_flag(block_name, 1'b1, out_valid);
        check_block(block_name, exp_block, out_rows);
    end
    if (idle_around) begin
        @(negedge clock);
        check_flag({name, " after drain"}, 1'b0, out_valid);
        // back onto the drive point
        @(posedge clock);
        #1;
    end
endtask

task automatic test_reset_state();
    check_flag("reset rhs_ready", 1'b1, rhs_ready);
    check_flag("reset lhs_ready", 1'b0, lhs_ready);
    check_flag("reset out_valid", 1'b0, out_valid);
    load_rhs(random_matrix());
    // held matrix opens the job port
    check_flag("loaded lhs_ready", 1'b1, lhs_ready);
endtask

task automatic test_identity();
    rhs_matrix_t m;
    lhs_job_t    job;
    result_t     expected;
    int unsigned accept_edge;
    m        = '0;
    expected = '0;
    // one nonzero per row, on the diagonal
    for (int k = 0; k < N; k++) begin
        m[k][k]         = data_t'(1);
        job.values[k]   = data_t'($random(seed));
        job.cols[k]     = col_idx_t'(k);
        job.row_ends[k] = row_end_t'(k + 1);
        expected[k][k]  = job.values[k];
    end
    load_rhs(m);
    issue_job(job, accept_edge);
    drain_expect("identity", accept_edge, expected, 1'b1);
endtask

task automatic test_random_job();
    lhs_job_t    job;
    int unsigned accept_edge;
    job = random_job();
    load_rhs(random_matrix());
    issue_job(job, accept_edge);
    drain_expect("random", accept_edge, ref_multiply(job, loaded_rhs), 1'b1);
endtask

task automatic test_back_to_back();
    for (int j = 0; j < BURST_JOBS; j++) begin
        burst_jobs[j] = random_job();
    end
    accept_q.delete();
    fork
        begin
            int unsigned acc_edge;
            for (int j = 0; j < BURST_JOBS; j++) begin
                issue_job(burst_jobs[j], acc_edge);
                accept_q.push_back(acc_edge);
            end
        end
        begin
            int unsigned acc_edge;
            for (int j = 0; j < BURST_JOBS; j++) begin
                while (accept_q.size() == 0) begin
                    @(negedge clock);
                end
                acc_edge = accept_q.pop_front();
                drain_expect($sformatf("burst job %0d", j), acc_edge,
                             ref_multiply(burst_jobs[j], loaded_rhs), 1'b0);
            end
        end
    join
    @(posedge clock);
    #1;
endtask

task automatic test_reload();
    rhs_matrix_t big;
    lhs_job_t    job;
    int unsigned accept_edge;
    job = random_job();
    // large values so nearly every product wraps
    for (int k = 0; k < N; k++) begin
        job.values[k] = data_t'(8'hc0 | ($random(seed) & 63));
    end
    for (int r = 0; r < N; r++) begin
        for (int c = 0; c < N; c++) begin
            big[r][c] = data_t'(8'hf0 | ($random(seed) & 15));
        end
    end
    issue_job(job, accept_edge);
    drain_expect("before reload", accept_edge, ref_multiply(job, loaded_rhs), 1'b1);
    load_rhs(big);
    issue_job(job, accept_edge);
    drain_expect("after reload", accept_edge, ref_multiply(job, big), 1'b1);
endtask

`endif

// File: verif/spmm_tb.sv
module spmm_tb
    import spmm_params_pkg::*, spmm_types_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 8;
    localparam int BURST_JOBS   = 6;
    // identity, random, burst, two around the reload
    localparam int NUM_JOBS     = BURST_JOBS + 4;
    localparam int NUM_LOADS    = 4;
    localparam int READY_WAIT   = 4 * (PIPE_LATENCY + NUM_BLOCKS);
    // twice the busy time, plus slack for gaps between tests
    localparam int RUN_CYCLES   = 2 * (NUM_JOBS * (PIPE_LATENCY + NUM_BLOCKS)
                                  + NUM_LOADS * (NUM_BLOCKS + 2)) + RESET_CYCLES + 100;

    logic        clock;
    logic        reset;
    logic        rhs_start;
    rhs_block_t  rhs_rows;
    logic        rhs_ready;
    logic        lhs_start;
    lhs_job_t    lhs_job;
    logic        lhs_ready;
    logic        out_valid;
    out_block_t  out_rows;

    int          errors;
    int          checks;
    int          seed;
    int unsigned edge_count = 0;
    // matrix the DUT currently holds
    rhs_matrix_t loaded_rhs;
    // burst jobs and their accepting edges, shared by issuer and collector
    lhs_job_t    burst_jobs [BURST_JOBS];
    int unsigned accept_q [$];

    spmm_top spmm_top_i (
        .clock     (clock),
        .reset     (reset),
        .rhs_start (rhs_start),
        .rhs_rows  (rhs_rows),
        .rhs_ready (rhs_ready),
        .lhs_start (lhs_start),
        .lhs_job   (lhs_job),
        .lhs_ready (lhs_ready),
        .out_valid (out_valid),
        .out_rows  (out_rows)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    // rising edges so far, read only at negedge or after the drive delay
    always @(posedge clock) begin
        edge_count <= edge_count + 1;
    end

    task automatic check_flag(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic check_block(input string name, input out_block_t expected,
                               input out_block_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // row r sums nonzeros from the previous row end up to its own end
    // everything wraps at 8 bits, rows with no nonzeros stay zero
    function automatic result_t ref_multiply(input lhs_job_t job, input rhs_matrix_t rhs);
        result_t res;
        int      first;
        int      last;
        res   = '0;
        first = 0;
        for (int r = 0; r < N; r++) begin
            last = int'(job.row_ends[r]);
            for (int k = first; k < last; k++) begin
                for (int c = 0; c < N; c++) begin
                    res[r][c] = res[r][c] + job.values[k] * rhs[job.cols[k]][c];
                end
            end
            first = last;
        end
        return res;
    endfunction

    `include "spmm_tests.svh"

    initial begin
        seed      = 32'h7bd5;
        errors    = 0;
        checks    = 0;
        reset     = 1'b1;
        rhs_start = 1'b0;
        rhs_rows  = '0;
        lhs_start = 1'b0;
        lhs_job   = '0;
        loaded_rhs = '0;
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        reset = 1'b0;
        test_reset_state();
        test_identity();
        test_random_job();
        test_back_to_back();
        test_reload();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        $display("watchdog: run did not finish within %0d cycles", RUN_CYCLES);
        $display("** FAIL **");
        $finish;
    end

endmodule

// File: files.f
+incdir+verif
src/spmm_params_pkg.sv
src/spmm_types_pkg.sv
src/rhs_loader.sv
src/job_decode.sv
src/product_array.sv
src/scan_level.sv
src/row_gather.sv
src/result_drain.sv
src/spmm_top.sv
verif/spmm_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the spmm testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
    -f files.f --top-module spmm_tb -Mdir obj_dir -o spmm_sim
./obj_dir/spmm_sim | tee sim.log

if grep -q '\*\* PASS \*\*' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
